//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= trigger_tb
FILELIST  ?= tlu_trigger.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/trigger_chk.sv
// concurrent checks on the accept FSM, bound into trigger_fsm
// soft_rst clears the counter, so it is kept out of the limit check
module trigger_chk (
    input logic                   BUS_CLK,
    input logic                   RST,
    input logic                   soft_rst,
    input trigger_pkg::trig_cfg_t cfg,
    input logic                   trigger_accepted,
    input logic                   trigger_acknowledge,
    input logic                   word_valid,
    input logic [31:0]            counter
);

    // req only rises once the consumer has dropped ack
    req_after_ack_low: assert property (@(posedge BUS_CLK) disable iff (RST)
        $rose(trigger_accepted) |-> !$past(trigger_acknowledge))
        else $error("trigger_accepted rose while trigger_acknowledge was high");

    word_with_req: assert property (@(posedge BUS_CLK) disable iff (RST)
        word_valid == $rose(trigger_accepted))
        else $error("word_valid and the rise of trigger_accepted are not aligned");

    // at or above a nonzero max the counter holds
    counter_stops_at_max: assert property (@(posedge BUS_CLK) disable iff (RST)
        (cfg.counter_max != '0 && counter >= cfg.counter_max && !cfg.counter_set && !soft_rst)
        |=> counter == $past(counter))
        else $error("trigger counter moved past counter_max");

endmodule

//--- dv/trigger_scoreboard.sv
// watches FIFO pops, bus reads and the external req/ack exchange
// expected words are queued by the testbench through exp_push
// exp_bus must be set together with bus_rd
// drain_check flags expected words that never came out of the FIFO
module trigger_scoreboard (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  logic        bus_rd,
    input  logic [7:0]  bus_data_out,
    input  logic        fifo_read,
    input  logic        fifo_empty,
    input  logic [31:0] fifo_data,
    input  logic        trigger_accepted,
    input  logic        trigger_acknowledge,
    input  logic        ext_trigger_enable,
    input  logic        exp_push,
    input  logic [31:0] exp_word,
    input  logic [7:0]  exp_bus,
    input  logic        drain_check,
    output int          errors,
    output int          checks
);
    logic [31:0] exp_q [$];
    logic        rd_pend;  // read data due on this edge
    logic [15:0] rd_addr;
    logic [7:0]  rd_exp;
    logic        req_d;
    logic        ack_d;

    always @(posedge BUS_CLK)
    begin : watch
        int e;
        int c;
        e = 0;
        c = 0;
        if (!RST)
        begin
            if (exp_push)
                exp_q.push_back(exp_word);
            if (fifo_read && !fifo_empty)
            begin
                c++;
                if (exp_q.size() == 0)
                begin
                    e++;
                    $display("unexpected FIFO word %h, no trigger should have been accepted",
                             fifo_data);
                end
                else
                begin
                    if (fifo_data !== exp_q[0])
                    begin
                        e++;
                        $display("mismatch fifo_data: got %h, expected %h", fifo_data, exp_q[0]);
                    end
                    void'(exp_q.pop_front());
                end
            end
            if (rd_pend)
            begin
                c++;
                if (bus_data_out !== rd_exp)
                begin
                    e++;
                    $display("mismatch bus_data_out at address %h: got %h, expected %h",
                             rd_addr, bus_data_out, rd_exp);
                end
            end
            if (drain_check && exp_q.size() != 0)
            begin
                e += exp_q.size();
                $display("%0d expected FIFO words never came out", exp_q.size());
                exp_q.delete();
            end
            // consumer owns ack here, so req may only drop after it
            if (ext_trigger_enable && req_d && !trigger_accepted && !ack_d)
            begin
                e++;
                $display("trigger_accepted fell before trigger_acknowledge was raised");
            end
        end
        rd_pend <= bus_rd && !RST;
        rd_addr <= bus_add;
        rd_exp  <= exp_bus;
        req_d   <= trigger_accepted;
        ack_d   <= trigger_acknowledge;
        if (RST)
        begin
            errors <= 0;
            checks <= 0;
        end
        else
        begin
            errors <= errors + e;
            checks <= checks + c;
        end
    end

endmodule

//--- dv/trigger_tb.sv
// testbench for the trigger controller, six directed tests
// channels and gaps are random from a fixed seed
// expected words come from a model counter kept here
// trigger inputs idle low except for an inverted channel
module trigger_tb;
    import trigger_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int CLK_PERIOD = 100;
    localparam int SETTLE     = 10;  // trigger edge to FIFO word is 7 cycles
    localparam int TEST_BUDGET = 150 + 200 + 200 + 300 + 200 + 400; // tests 1 to 6
    localparam int MARGIN     = 500;
    localparam logic [31:0] SEED = 32'h97f3_de2e;
    localparam logic [7:0] CFG_ADDR [8] = '{ADDR_CONF, ADDR_TRIG_SEL, ADDR_VETO_SEL,
        ADDR_TRIG_INV, ADDR_MAX0, ADDR_MAX1, ADDR_MAX2, ADDR_MAX3};

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic [7:0]  trigger;
    logic [7:0]  trigger_veto;
    logic        ext_trigger_enable;
    logic        trigger_acknowledge;
    logic        trigger_accepted;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        exp_push;
    logic [31:0] exp_word;
    logic [7:0]  exp_bus;
    logic        drain_check;
    int          sb_errors;
    int          sb_checks;
    logic [31:0] model_cnt;  // accepted triggers since the last preset
    int          tb_errors = 0;
    int          test_num = 0;
    int          failed_tests = 0;
    int          err_mark = 0;

    trigger_top #(.FIFO_DEPTH(FIFO_DEPTH), .ABUSWIDTH(16)) UUT (.*);

    trigger_scoreboard u_sb (
        .BUS_CLK, .RST, .bus_add, .bus_rd, .bus_data_out,
        .fifo_read, .fifo_empty, .fifo_data,
        .trigger_accepted, .trigger_acknowledge, .ext_trigger_enable,
        .exp_push, .exp_word, .exp_bus, .drain_check,
        .errors(sb_errors), .checks(sb_checks)
    );

    bind trigger_fsm trigger_chk u_chk (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .cfg(cfg),
        .trigger_accepted(trigger_accepted), .trigger_acknowledge(trigger_acknowledge),
        .word_valid(word_valid), .counter(counter)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    // marker on top of the count before the increment
    function automatic logic [31:0] ref_word(input logic [31:0] cnt);
        return {1'b1, cnt[30:0]};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge BUS_CLK);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= {8'h00, addr};
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [7:0] addr, input logic [7:0] exp);
        @(posedge BUS_CLK);
        bus_add <= {8'h00, addr};
        bus_rd  <= 1'b1;
        exp_bus <= exp;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(posedge BUS_CLK);  // data compared on this edge
    endtask

    task automatic write32(input logic [7:0] addr0, input logic [31:0] value);
        for (int i = 0; i < 4; i++)
            bus_write(addr0 + 8'(i), value[8*i +: 8]);
    endtask

    // byte 0 read latches bytes 1..3
    task automatic check_counter(input logic [31:0] exp);
        for (int i = 0; i < 4; i++)
            bus_read_check(ADDR_CNT0 + 8'(i), exp[8*i +: 8]);
    endtask

    task automatic soft_reset();
        bus_write(8'h00, 8'h00);
        model_cnt = '0;
        idle(2);
    endtask

    task automatic expect_word(input logic [31:0] w);
        @(posedge BUS_CLK);
        exp_push <= 1'b1;
        exp_word <= w;
        @(posedge BUS_CLK);
        exp_push <= 1'b0;
    endtask

    // toggle channels away from idle and back
    task automatic fire(input logic [7:0] mask);
        @(posedge BUS_CLK);
        trigger <= trigger ^ mask;
        idle(2);
        trigger <= trigger ^ mask;
    endtask

    task automatic wait_word();
        int n;
        n = 0;
        while (fifo_empty && n < 4 * SETTLE)
        begin
            @(posedge BUS_CLK);
            n++;
        end
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (trigger_accepted != level && n < 4 * SETTLE)
        begin
            @(posedge BUS_CLK);
            n++;
        end
        if (trigger_accepted != level)
        begin
            tb_errors++;
            $display("trigger_accepted did not go to %0d within %0d cycles", level, 4 * SETTLE);
        end
    endtask

    task automatic drain();
        for (int i = 0; i < FIFO_DEPTH + 2 && !fifo_empty; i++)
        begin
            @(posedge BUS_CLK);
            fifo_read <= 1'b1;
            @(posedge BUS_CLK);
            fifo_read <= 1'b0;
            @(posedge BUS_CLK);
        end
        @(posedge BUS_CLK);
        drain_check <= 1'b1;
        @(posedge BUS_CLK);
        drain_check <= 1'b0;
    endtask

    task automatic trigger_and_expect(input logic [7:0] mask);
        expect_word(ref_word(model_cnt));
        model_cnt = model_cnt + 32'd1;
        fire(mask);
        wait_word();
        drain();
    endtask

    task automatic trigger_and_ignore(input logic [7:0] mask);
        fire(mask);
        idle(SETTLE);
        drain();
    endtask

    task automatic setup(input logic [7:0] sel, input logic [7:0] conf);
        bus_write(ADDR_TRIG_SEL, sel);
        bus_write(ADDR_CONF, conf);
    endtask

    task automatic end_test(input string name);
        int errs;
        idle(2);
        errs = sb_errors + tb_errors - err_mark;
        test_num++;
        if (errs == 0)
            $display("test %0d %s: passed", test_num, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_num, name, errs);
        end
        err_mark = sb_errors + tb_errors;
    endtask

    initial
    begin
        int          ch;
        int          v;
        int          extra;
        logic [7:0]  mask;
        logic [7:0]  en;
        logic [31:0] preset;
        logic [7:0]  cfg_val [8];
        void'($urandom(SEED));
        en = 8'(1 << CONF_ENABLE_BIT);
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read = 1'b0;
        exp_push = 1'b0;
        exp_word = '0;
        exp_bus = '0;
        drain_check = 1'b0;
        model_cnt = '0;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;
        idle(2);

        bus_read_check(8'h00, VERSION);
        for (int i = 0; i < 8; i++)
        begin
            cfg_val[i] = 8'($urandom);
            if (i == 0)
                cfg_val[i] = cfg_val[i] & ~en;  // no triggers while masks change
            bus_write(CFG_ADDR[i], cfg_val[i]);
        end
        for (int i = 0; i < 8; i++)
            bus_read_check(CFG_ADDR[i], cfg_val[i]);
        soft_reset();
        for (int i = 0; i < 8; i++)
            bus_read_check(CFG_ADDR[i], 8'h00);
        end_test("register access");

        ch = $urandom % 8;
        mask = 8'(1 << ch);
        setup(mask, en);
        trigger_and_expect(mask);
        check_counter(model_cnt);
        ch = $urandom % 8;
        mask = 8'(1 << ch);
        bus_write(ADDR_TRIG_SEL, 8'h00);
        @(posedge BUS_CLK);
        trigger <= mask;  // inverted channel idles high
        bus_write(ADDR_TRIG_INV, mask);
        bus_write(ADDR_TRIG_SEL, mask);
        trigger_and_expect(mask);
        check_counter(model_cnt);
        end_test("trigger word");

        soft_reset();
        @(posedge BUS_CLK);
        trigger <= '0;
        ch = $urandom % 8;
        mask = 8'(1 << ch);
        setup(mask, en);
        trigger_and_ignore(~mask);
        check_counter(model_cnt);
        v = $urandom % 8;
        bus_write(ADDR_VETO_SEL, 8'(1 << v));
        @(posedge BUS_CLK);
        trigger_veto <= 8'(1 << v);
        idle(4);
        trigger_and_ignore(mask);
        @(posedge BUS_CLK);
        trigger_veto <= '0;
        idle(4);
        check_counter(model_cnt);
        trigger_and_expect(mask);  // veto gone, accepted again
        end_test("masked and vetoed");

        soft_reset();
        setup(mask, en);
        preset = $urandom & 32'h00ff_ffff;
        write32(ADDR_MAX0, preset + 32'd3);
        write32(ADDR_CNT0, preset);
        model_cnt = preset;
        check_counter(model_cnt);
        for (int i = 0; i < 5; i++)
        begin
            if (model_cnt < preset + 32'd3)
                trigger_and_expect(mask);
            else
                trigger_and_ignore(mask);
        end
        check_counter(model_cnt);
        end_test("preset and limit");

        soft_reset();
        setup(mask, 8'h00);
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b1;
        expect_word(ref_word(model_cnt));
        model_cnt = model_cnt + 32'd1;
        fire(mask);
        wait_req(1'b1);
        fire(mask);  // lands while req is high
        idle(4);
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b1;
        wait_req(1'b0);
        fire(mask);  // lands while ack is still high
        idle(SETTLE);
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b0;
        idle(2);
        drain();
        check_counter(model_cnt);
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b0;
        end_test("external handshake");

        soft_reset();
        setup(mask, en);
        extra = 1 + $urandom % 3;
        for (int i = 0; i < FIFO_DEPTH + extra; i++)
        begin
            if (i < FIFO_DEPTH)
                expect_word(ref_word(model_cnt));
            model_cnt = model_cnt + 32'd1;  // counted even when dropped
            fire(mask);
            idle(SETTLE + $urandom % 4);
        end
        bus_read_check(ADDR_LOST, 8'(extra));
        drain();
        check_counter(model_cnt);
        end_test("FIFO overflow");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, failed_tests, sb_checks, sb_errors + tb_errors);
        if (sb_errors + tb_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #((TEST_BUDGET + MARGIN) * CLK_PERIOD);
        $display("watchdog timeout, tests did not finish within %0d cycles",
                 TEST_BUDGET + MARGIN);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tlu_trigger.f
verilog/trigger_pkg.sv
verilog/trigger_regs.sv
verilog/trigger_input.sv
verilog/trigger_fsm.sv
verilog/trigger_fifo.sv
verilog/trigger_top.sv
dv/trigger_chk.sv
dv/trigger_scoreboard.sv
dv/trigger_tb.sv

//--- verilog/trigger_fifo.sv
// output FIFO for trigger words, first-word-fall-through
// FIFO_DEPTH must be a power of two
// no back-pressure: words arriving while full are dropped and counted
// lost_cnt saturates at 255
module trigger_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic                    soft_rst,
    input  logic                    word_valid,
    input  trigger_pkg::trig_word_t word,
    input  logic                    fifo_read,
    output logic                    fifo_empty,
    output logic [31:0]             fifo_data,
    output logic [7:0]              lost_cnt
);
    import trigger_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    trig_word_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             full;
    logic             push;
    logic             pop;

    assign full       = (fill == (PTR_W + 1)'(FIFO_DEPTH));
    assign fifo_empty = (fill == '0);
    assign push       = word_valid && !full;
    assign pop        = fifo_read && !fifo_empty;
    assign fifo_data  = mem[rd_ptr]; // head word, valid while not empty

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2**n
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
            if (word_valid && full && lost_cnt != 8'hff)
                lost_cnt <= lost_cnt + 8'd1;
        end
    end

endmodule

//--- verilog/trigger_fsm.sv
// trigger accept FSM with four-phase req/ack to the consumer
// without ext_trigger_enable the FSM acks itself, so req lasts one cycle
// pulses outside IDLE are dropped, nothing is queued
// counter_max of 0 disables the limit stop
module trigger_fsm (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic                    soft_rst,
    input  trigger_pkg::trig_cfg_t  cfg,
    input  logic                    trig_pulse,
    input  logic                    veto,
    input  logic                    ext_trigger_enable,
    input  logic                    trigger_acknowledge,
    output logic                    trigger_accepted,
    output logic [31:0]             counter,
    output logic                    word_valid,
    output trigger_pkg::trig_word_t word
);
    import trigger_pkg::*;

    trig_state_t state;
    logic        ack;
    logic        enabled;
    logic        limit_reached;
    logic        accept;
    logic [31:0] word_bits;

    assign ack     = ext_trigger_enable ? trigger_acknowledge : trigger_accepted;
    assign enabled = ext_trigger_enable | cfg.enable;
    assign limit_reached = (cfg.counter_max != '0) && (counter >= cfg.counter_max);
    assign accept  = (state == IDLE) && trig_pulse && enabled && !veto && !limit_reached;

    always_comb
    begin
        word_bits = counter; // value before the increment
        word_bits[DATA_MARKER] = 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            state            <= IDLE;
            trigger_accepted <= 1'b0;
            word_valid       <= 1'b0;
            counter          <= '0;
        end
        else
        begin
            word_valid <= accept;
            case (state)
                IDLE:
                    if (accept)
                    begin
                        state            <= ACCEPT;
                        trigger_accepted <= 1'b1;
                    end
                ACCEPT:
                    if (ack)
                    begin
                        state            <= WAIT_ACK_LOW;
                        trigger_accepted <= 1'b0;
                    end
                WAIT_ACK_LOW:
                    if (!ack)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
            if (cfg.counter_set)
                counter <= cfg.counter_set_value; // preset wins over increment
            else if (accept)
                counter <= counter + 32'd1;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            word <= word_bits;
    end

endmodule

//--- verilog/trigger_input.sv
// trigger input conditioning
// channels are async to BUS_CLK and go through three flops after masking
// trig_pulse comes 4 cycles after a trigger input edge, veto after 3
module trigger_input (
    input  logic                                BUS_CLK,
    input  logic                                RST,
    input  trigger_pkg::trig_cfg_t              cfg,
    input  logic [trigger_pkg::CH_WIDTH-1:0]    trigger,
    input  logic [trigger_pkg::CH_WIDTH-1:0]    trigger_veto,
    output logic                                trig_pulse,
    output logic                                veto
);
    import trigger_pkg::*;

    logic [CH_WIDTH-1:0] active;
    logic                trig_or;
    logic                veto_or;
    logic [1:0]          sync [3]; // bit 0 trigger, bit 1 veto
    logic                trig_d;

    // a channel is active when it differs from its invert bit
    assign active  = (trigger ^ cfg.trigger_invert) & cfg.trigger_select;
    assign trig_or = |active;
    assign veto_or = |(trigger_veto & cfg.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            sync[0]    <= '0;
            sync[1]    <= '0;
            sync[2]    <= '0;
            trig_d     <= 1'b0;
            trig_pulse <= 1'b0;
        end
        else
        begin
            sync[0]    <= {veto_or, trig_or};
            sync[1]    <= sync[0];
            sync[2]    <= sync[1];
            trig_d     <= sync[2][0];
            trig_pulse <= sync[2][0] & ~trig_d; // rising edge only
        end
    end

    assign veto = sync[2][1];

endmodule

//--- verilog/trigger_pkg.sv
// shared constants and types for the trigger controller
// channel width is fixed at 8, one register byte per mask
// register map follows the standard trigger path; TLU registers are absent
package trigger_pkg;

    localparam logic [7:0] VERSION = 8'd10;

    localparam int CH_WIDTH = 8;

    // bus register addresses
    localparam logic [7:0] ADDR_CONF     = 8'd1;
    localparam logic [7:0] ADDR_CNT0     = 8'd8;
    localparam logic [7:0] ADDR_CNT1     = 8'd9;
    localparam logic [7:0] ADDR_CNT2     = 8'd10;
    localparam logic [7:0] ADDR_CNT3     = 8'd11;
    localparam logic [7:0] ADDR_LOST     = 8'd12;
    localparam logic [7:0] ADDR_TRIG_SEL = 8'd13;
    localparam logic [7:0] ADDR_VETO_SEL = 8'd17;
    localparam logic [7:0] ADDR_TRIG_INV = 8'd21;
    localparam logic [7:0] ADDR_MAX0     = 8'd25;
    localparam logic [7:0] ADDR_MAX1     = 8'd26;
    localparam logic [7:0] ADDR_MAX2     = 8'd27;
    localparam logic [7:0] ADDR_MAX3     = 8'd28;

    localparam int CONF_ENABLE_BIT = 3;  // bus trigger enable in conf byte
    localparam int DATA_MARKER     = 31; // set in every trigger word

    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,
        WAIT_ACK_LOW
    } trig_state_t;

    typedef struct packed {
        logic                enable;
        logic [CH_WIDTH-1:0] trigger_select;
        logic [CH_WIDTH-1:0] veto_select;
        logic [CH_WIDTH-1:0] trigger_invert;
        logic [31:0]         counter_max;       // 0 means no limit
        logic                counter_set;       // one cycle pulse
        logic [31:0]         counter_set_value;
    } trig_cfg_t;

    typedef struct packed {
        logic        marker;
        logic [30:0] number;
    } trig_word_t;

endpackage

//--- verilog/trigger_regs.sv
// bus register bank of the trigger controller
// writes land on the bus_wr cycle, read data comes one cycle after bus_rd
// a write to address 0 raises soft_rst for one cycle, clearing everything
// reading counter byte 0 latches the upper bytes for the following reads
module trigger_regs #(
    parameter int ABUSWIDTH = 16
) (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic [ABUSWIDTH-1:0]   bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_rd,
    input  logic                   bus_wr,
    output logic [7:0]             bus_data_out,
    output trigger_pkg::trig_cfg_t cfg,
    output logic                   soft_rst,
    input  logic [31:0]            counter,
    input  logic [7:0]             lost_cnt
);
    import trigger_pkg::*;

    logic [7:0]       conf;
    logic [7:0]       trig_sel;
    logic [7:0]       veto_sel;
    logic [7:0]       trig_inv;
    logic [3:0][7:0]  cnt_max;
    logic [3:0][7:0]  preset;    // counter preset bytes
    logic             cnt_set;
    logic [31:0]      cnt_buf;   // upper bytes for reads of 9..11

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus_wr && (bus_add == '0);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            conf     <= '0;
            trig_sel <= '0;
            veto_sel <= '0;
            trig_inv <= '0;
            cnt_max  <= '0;
            preset   <= '0;
            cnt_set  <= 1'b0;
        end
        else
        begin
            cnt_set <= bus_wr && (bus_add == ABUSWIDTH'(ADDR_CNT3)); // preset on top byte
            if (bus_wr)
            begin
                case (bus_add)
                    ABUSWIDTH'(ADDR_CONF):     conf <= bus_data_in;
                    ABUSWIDTH'(ADDR_CNT0):     preset[0] <= bus_data_in;
                    ABUSWIDTH'(ADDR_CNT1):     preset[1] <= bus_data_in;
                    ABUSWIDTH'(ADDR_CNT2):     preset[2] <= bus_data_in;
                    ABUSWIDTH'(ADDR_CNT3):     preset[3] <= bus_data_in;
                    ABUSWIDTH'(ADDR_TRIG_SEL): trig_sel <= bus_data_in;
                    ABUSWIDTH'(ADDR_VETO_SEL): veto_sel <= bus_data_in;
                    ABUSWIDTH'(ADDR_TRIG_INV): trig_inv <= bus_data_in;
                    ABUSWIDTH'(ADDR_MAX0):     cnt_max[0] <= bus_data_in;
                    ABUSWIDTH'(ADDR_MAX1):     cnt_max[1] <= bus_data_in;
                    ABUSWIDTH'(ADDR_MAX2):     cnt_max[2] <= bus_data_in;
                    ABUSWIDTH'(ADDR_MAX3):     cnt_max[3] <= bus_data_in;
                    default:                   ;
                endcase
            end
        end
    end

    always_comb
    begin
        cfg.enable            = conf[CONF_ENABLE_BIT];
        cfg.trigger_select    = trig_sel;
        cfg.veto_select       = veto_sel;
        cfg.trigger_invert    = trig_inv;
        cfg.counter_max       = cnt_max;
        cfg.counter_set       = cnt_set;
        cfg.counter_set_value = preset; // byte 3 stored on the same edge as the pulse
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            cnt_buf <= '0;
        else if (bus_rd && (bus_add == ABUSWIDTH'(ADDR_CNT0)))
            cnt_buf <= counter;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd)
        begin
            case (bus_add)
                ABUSWIDTH'(0):             bus_data_out <= VERSION;
                ABUSWIDTH'(ADDR_CONF):     bus_data_out <= conf;
                ABUSWIDTH'(ADDR_CNT0):     bus_data_out <= counter[7:0]; // live byte
                ABUSWIDTH'(ADDR_CNT1):     bus_data_out <= cnt_buf[15:8];
                ABUSWIDTH'(ADDR_CNT2):     bus_data_out <= cnt_buf[23:16];
                ABUSWIDTH'(ADDR_CNT3):     bus_data_out <= cnt_buf[31:24];
                ABUSWIDTH'(ADDR_LOST):     bus_data_out <= lost_cnt;
                ABUSWIDTH'(ADDR_TRIG_SEL): bus_data_out <= trig_sel;
                ABUSWIDTH'(ADDR_VETO_SEL): bus_data_out <= veto_sel;
                ABUSWIDTH'(ADDR_TRIG_INV): bus_data_out <= trig_inv;
                ABUSWIDTH'(ADDR_MAX0):     bus_data_out <= cnt_max[0];
                ABUSWIDTH'(ADDR_MAX1):     bus_data_out <= cnt_max[1];
                ABUSWIDTH'(ADDR_MAX2):     bus_data_out <= cnt_max[2];
                ABUSWIDTH'(ADDR_MAX3):     bus_data_out <= cnt_max[3];
                default:                   bus_data_out <= 8'd0;
            endcase
        end
    end

endmodule

//--- verilog/trigger_top.sv
// trigger controller top, everything on BUS_CLK
// trigger and trigger_veto are 8 channels each
// fifo_data is valid whenever fifo_empty is low
module trigger_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int ABUSWIDTH  = 16
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]           bus_data_in,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    output logic [7:0]           bus_data_out,
    input  logic [7:0]           trigger,
    input  logic [7:0]           trigger_veto,
    input  logic                 ext_trigger_enable,
    input  logic                 trigger_acknowledge,
    output logic                 trigger_accepted,
    input  logic                 fifo_read,
    output logic                 fifo_empty,
    output logic [31:0]          fifo_data
);
    import trigger_pkg::*;

    trig_cfg_t   cfg;
    trig_word_t  word;
    logic        soft_rst;
    logic        trig_pulse;
    logic        veto;
    logic        word_valid;
    logic [31:0] counter;
    logic [7:0]  lost_cnt;

    trigger_regs #(.ABUSWIDTH(ABUSWIDTH)) u_regs (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_data_out(bus_data_out),
        .cfg(cfg), .soft_rst(soft_rst), .counter(counter), .lost_cnt(lost_cnt)
    );

    trigger_input u_input (
        .BUS_CLK(BUS_CLK), .RST(RST), .cfg(cfg),
        .trigger(trigger), .trigger_veto(trigger_veto),
        .trig_pulse(trig_pulse), .veto(veto)
    );

    trigger_fsm u_fsm (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .cfg(cfg),
        .trig_pulse(trig_pulse), .veto(veto),
        .ext_trigger_enable(ext_trigger_enable),
        .trigger_acknowledge(trigger_acknowledge),
        .trigger_accepted(trigger_accepted), .counter(counter),
        .word_valid(word_valid), .word(word)
    );

    trigger_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst),
        .word_valid(word_valid), .word(word), .fifo_read(fifo_read),
        .fifo_empty(fifo_empty), .fifo_data(fifo_data), .lost_cnt(lost_cnt)
    );

endmodule
